// ==== soc_pkg.sv ====
package soc_pkg;

   // Widths with a meaning on the bus
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  region_t;
   typedef logic [15:0] offset_t;
   typedef logic [3:0]  exc_code_t;

   localparam int NUM_TIMERS = 4;

   // One pending bit per timer
   typedef logic [NUM_TIMERS-1:0] irq_vec_t;

   // Region is addr[31:28], anything else is unmapped
   localparam region_t REGION_RAM   = 4'h0;
   localparam region_t REGION_TIMER = 4'h2;

   // Exception codes seen by the CPU
   localparam exc_code_t EXC_RESET  = 4'h0;
   localparam exc_code_t EXC_TIMER0 = 4'h1;
   localparam exc_code_t EXC_TIMER1 = 4'h2;
   localparam exc_code_t EXC_TIMER2 = 4'h3;
   localparam exc_code_t EXC_TIMER3 = 4'h4;
   localparam exc_code_t EXC_MMU    = 4'h5;

   // Timer bank status register, compares sit below it
   localparam offset_t TMR_STATUS_OFFSET = 16'd4;

   // Master request, 66 bits
   typedef struct packed {
      addr_t addr;
      logic  write;
      data_t wdata;
      logic  supervisor;
   } bus_req_t;

   // Master response, 33 bits
   typedef struct packed {
      data_t rdata;
      logic  err;
   } bus_rsp_t;

   // Decoded request toward a slave
   typedef struct packed {
      offset_t offset;
      logic    write;
      data_t   wdata;
   } slv_req_t;

endpackage

// ==== bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder #(
   parameter int unsigned RAM_WORDS = 256
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              req_valid_i,
   input  soc_pkg::bus_req_t req_i,
   output logic              req_ready_o,
   output logic              rsp_valid_o,
   output soc_pkg::bus_rsp_t rsp_o,
   input  logic              rsp_ready_i,
   output soc_pkg::slv_req_t slv_req_o,
   output logic              ram_stb_o,
   output logic              tmr_stb_o,
   input  soc_pkg::data_t    ram_rdata_i,
   input  soc_pkg::data_t    tmr_rdata_i,
   output logic              fault_o
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      RESPOND
   } state_e;

   state_e            state_q;
   soc_pkg::region_t  region;
   logic [25:0]       word_idx;
   logic              hit_ram;
   logic              hit_tmr;
   logic              accept;
   logic              sel_ram_q;
   logic              sel_tmr_q;
   logic              err_q;
   logic              rsp_valid_q;
   soc_pkg::slv_req_t slv_req_q;
   soc_pkg::bus_rsp_t rsp_q;
   soc_pkg::data_t    slv_rdata;

   // Region and word index of the incoming request
   assign region   = req_i.addr[31:28];
   assign word_idx = req_i.addr[27:2];

   // Legal targets, everything else faults
   assign hit_ram = (region == soc_pkg::REGION_RAM) && (32'(word_idx) < RAM_WORDS);
   assign hit_tmr = (region == soc_pkg::REGION_TIMER) && req_i.supervisor;

   assign req_ready_o = (state_q == IDLE);
   assign accept      = req_valid_i && req_ready_o;

   // Slaves only see legal requests
   assign slv_req_o = slv_req_q;
   assign ram_stb_o = (state_q == ACCESS) && sel_ram_q;
   assign tmr_stb_o = (state_q == ACCESS) && sel_tmr_q;
   assign fault_o   = (state_q == ACCESS) && err_q;

   // Faulted requests return zero
   assign slv_rdata = sel_ram_q ? ram_rdata_i :
                      sel_tmr_q ? tmr_rdata_i : '0;

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q     <= IDLE;
         sel_ram_q   <= 1'b0;
         sel_tmr_q   <= 1'b0;
         err_q       <= 1'b0;
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (accept)
               begin
                  sel_ram_q <= hit_ram;
                  sel_tmr_q <= hit_tmr;
                  err_q     <= !(hit_ram || hit_tmr);
                  state_q   <= ACCESS;
               end
            end
            ACCESS:
            begin
               state_q <= RESPOND;
            end
            RESPOND:
            begin
               // First cycle captures the slave data, then wait for the master
               if (!rsp_valid_q)
               begin
                  rsp_valid_q <= 1'b1;
               end
               else if (rsp_ready_i)
               begin
                  rsp_valid_q <= 1'b0;
                  state_q     <= IDLE;
               end
            end
            default:
            begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         slv_req_q.offset <= req_i.addr[17:2];
         slv_req_q.write  <= req_i.write;
         slv_req_q.wdata  <= req_i.wdata;
      end
      if (state_q == RESPOND && !rsp_valid_q)
      begin
         rsp_q.rdata <= slv_rdata;
         rsp_q.err   <= err_q;
      end
   end

endmodule

// ==== sram_slave.sv ====
`timescale 1ns/10ps

module sram_slave #(
   parameter int unsigned RAM_WORDS = 256
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              stb_i,
   input  soc_pkg::slv_req_t slv_req_i,
   output soc_pkg::data_t    rdata_o
);

   localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

   soc_pkg::data_t mem [RAM_WORDS];
   logic [AW-1:0]  idx;
   logic           wr;

   // Decoder already checked the bounds
   assign idx = slv_req_i.offset[AW-1:0];
   assign wr  = stb_i && slv_req_i.write;

   always_ff @(posedge clk_i)
   begin
      if (wr)
      begin
         mem[idx] <= slv_req_i.wdata;
      end
   end

   // Writes echo the stored word back
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rdata_o <= '0;
      end
      else if (stb_i)
      begin
         rdata_o <= wr ? slv_req_i.wdata : mem[idx];
      end
   end

endmodule

// ==== timer_bank.sv ====
`timescale 1ns/10ps

module timer_bank #(
   parameter int unsigned PRESCALE = 4
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              stb_i,
   input  soc_pkg::slv_req_t slv_req_i,
   output soc_pkg::data_t    rdata_o,
   output soc_pkg::irq_vec_t irq_o
);

   localparam int PS_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

   logic [PS_W-1:0]   ps_cnt_q;
   logic              tick;
   soc_pkg::data_t    compare_q [soc_pkg::NUM_TIMERS];
   soc_pkg::data_t    count_q [soc_pkg::NUM_TIMERS];
   soc_pkg::irq_vec_t pending_q;
   soc_pkg::irq_vec_t cmp_wr;
   soc_pkg::irq_vec_t expire;
   soc_pkg::irq_vec_t clr;
   soc_pkg::data_t    rd_data;
   logic              wr;

   assign wr   = stb_i && slv_req_i.write;
   assign tick = (ps_cnt_q == PS_W'(PRESCALE - 1));

   // Status write clears the bits that are set in the data
   assign clr = (wr && slv_req_i.offset == soc_pkg::TMR_STATUS_OFFSET) ?
                slv_req_i.wdata[soc_pkg::NUM_TIMERS-1:0] : '0;

   always_comb
   begin
      for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      begin
         cmp_wr[i] = wr && (slv_req_i.offset == soc_pkg::offset_t'(i));
         // A disabled or freshly written timer does not fire
         expire[i] = tick && !cmp_wr[i] && (compare_q[i] != '0) &&
                     (count_q[i] == compare_q[i] - 32'd1);
      end
   end

   // Register read mux, unused offsets are zero
   always_comb
   begin
      rd_data = '0;
      for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      begin
         if (slv_req_i.offset == soc_pkg::offset_t'(i))
         begin
            rd_data = compare_q[i];
         end
      end
      if (slv_req_i.offset == soc_pkg::TMR_STATUS_OFFSET)
      begin
         rd_data = soc_pkg::data_t'(pending_q);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ps_cnt_q  <= '0;
         pending_q <= '0;
         rdata_o   <= '0;
         for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
         begin
            compare_q[i] <= '0;
            count_q[i]   <= '0;
         end
      end
      else
      begin
         ps_cnt_q <= tick ? '0 : ps_cnt_q + 1'b1;

         for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
         begin
            if (cmp_wr[i])
            begin
               compare_q[i] <= slv_req_i.wdata;
               count_q[i]   <= '0;
            end
            else if (expire[i])
            begin
               count_q[i] <= '0;
            end
            else if (tick && compare_q[i] != '0)
            begin
               count_q[i] <= count_q[i] + 32'd1;
            end
         end

         // New expiry wins over a clear in the same cycle
         pending_q <= (pending_q & ~clr) | expire;

         if (stb_i)
         begin
            rdata_o <= rd_data;
         end
      end
   end

   assign irq_o = pending_q;

endmodule

// ==== interrupt_encoder.sv ====
`timescale 1ns/10ps

module interrupt_encoder (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                fault_i,
   input  soc_pkg::irq_vec_t   irq_i,
   input  logic                int_en_i,
   input  logic                int_ack_i,
   output soc_pkg::exc_code_t  cpu_interrupt_o
);

   logic fault_q;

   // Fault stays latched until the CPU acknowledges it
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         fault_q <= 1'b0;
      end
      else if (fault_i)
      begin
         fault_q <= 1'b1;
      end
      else if (int_ack_i)
      begin
         fault_q <= 1'b0;
      end
   end

   // Fixed priority, MMU first then the highest timer
   always_comb
   begin
      cpu_interrupt_o = soc_pkg::EXC_RESET;
      if (int_en_i)
      begin
         casez ({fault_q, irq_i})
            5'b1????: cpu_interrupt_o = soc_pkg::EXC_MMU;
            5'b01???: cpu_interrupt_o = soc_pkg::EXC_TIMER3;
            5'b001??: cpu_interrupt_o = soc_pkg::EXC_TIMER2;
            5'b0001?: cpu_interrupt_o = soc_pkg::EXC_TIMER1;
            5'b00001: cpu_interrupt_o = soc_pkg::EXC_TIMER0;
            default:  cpu_interrupt_o = soc_pkg::EXC_RESET;
         endcase
      end
   end

endmodule

// ==== soc_core.sv ====
`timescale 1ns/10ps

module soc_core #(
   parameter int unsigned RAM_WORDS = 256,
   parameter int unsigned PRESCALE  = 4
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               req_valid_i,
   input  soc_pkg::bus_req_t  req_i,
   output logic               req_ready_o,
   output logic               rsp_valid_o,
   output soc_pkg::bus_rsp_t  rsp_o,
   input  logic               rsp_ready_i,
   input  logic               int_en_i,
   input  logic               int_ack_i,
   output soc_pkg::exc_code_t cpu_interrupt_o
);

   soc_pkg::slv_req_t slv_req;
   logic              ram_stb;
   logic              tmr_stb;
   soc_pkg::data_t    ram_rdata;
   soc_pkg::data_t    tmr_rdata;
   soc_pkg::irq_vec_t tmr_irq;
   logic              fault;

   // Request decode and privilege check
   bus_decoder #(
      .RAM_WORDS (RAM_WORDS)
   ) u_bus_decoder (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_ready_o (req_ready_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o),
      .rsp_ready_i (rsp_ready_i),
      .slv_req_o   (slv_req),
      .ram_stb_o   (ram_stb),
      .tmr_stb_o   (tmr_stb),
      .ram_rdata_i (ram_rdata),
      .tmr_rdata_i (tmr_rdata),
      .fault_o     (fault)
   );

   sram_slave #(
      .RAM_WORDS (RAM_WORDS)
   ) u_sram_slave (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .stb_i     (ram_stb),
      .slv_req_i (slv_req),
      .rdata_o   (ram_rdata)
   );

   timer_bank #(
      .PRESCALE (PRESCALE)
   ) u_timer_bank (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .stb_i     (tmr_stb),
      .slv_req_i (slv_req),
      .rdata_o   (tmr_rdata),
      .irq_o     (tmr_irq)
   );

   // Exception code for the CPU
   interrupt_encoder u_interrupt_encoder (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .fault_i         (fault),
      .irq_i           (tmr_irq),
      .int_en_i        (int_en_i),
      .int_ack_i       (int_ack_i),
      .cpu_interrupt_o (cpu_interrupt_o)
   );

endmodule

// ==== tb_soc_core.sv ====
`timescale 1ns/10ps

module tb_soc_core;

   localparam int unsigned    RAM_WORDS = 256;
   localparam int unsigned    PRESCALE  = 4;
   localparam int             TIMEOUT   = 400;
   localparam soc_pkg::addr_t TMR_BASE  = 32'h2000_0000;

   logic               clk_i;
   logic               rst_n_i;
   logic               req_valid_i;
   soc_pkg::bus_req_t  req_i;
   logic               req_ready_o;
   logic               rsp_valid_o;
   soc_pkg::bus_rsp_t  rsp_o;
   logic               rsp_ready_i;
   logic               int_en_i;
   logic               int_ack_i;
   soc_pkg::exc_code_t cpu_interrupt_o;

   // Expected RAM contents
   soc_pkg::data_t model [RAM_WORDS];
   soc_pkg::data_t rdata;
   logic           err;
   int unsigned    off;
   int             polls;

   soc_core #(
      .RAM_WORDS (RAM_WORDS),
      .PRESCALE  (PRESCALE)
   ) u_soc_core (.*);

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #20 clk_i = ~clk_i;
      end
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         fail_run($sformatf("ERROR at %0t: %s expected 0x%0h actual 0x%0h",
                            $time, name, expected, actual));
      end
   endtask

   // Only one request in flight, so the request side stays closed
   ready_closed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  rsp_valid_o |-> !req_ready_o)
   else
   begin
      fail_run($sformatf("ERROR at %0t: req_ready_o expected 0x0 actual 0x%0h",
                         $time, $sampled(req_ready_o)));
   end

   rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              rsp_valid_o && !rsp_ready_i |=> rsp_valid_o)
   else
   begin
      fail_run($sformatf("ERROR at %0t: rsp_valid_o expected 0x1 actual 0x%0h",
                         $time, $sampled(rsp_valid_o)));
   end

   // One request with the response held back for hold cycles
   task automatic bus_transfer(input logic write, input soc_pkg::addr_t addr,
                               input soc_pkg::data_t wdata, input logic sup,
                               input int hold, output soc_pkg::data_t rd,
                               output logic rd_err);
      soc_pkg::bus_rsp_t held;
      int                n;
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_i       <= '{addr: addr, write: write, wdata: wdata, supervisor: sup};
      rsp_ready_i <= (hold == 0);
      n = 0;
      do
      begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT)
         begin
            fail_run("Timeout waiting for the core to accept a request");
         end
      end while (!req_ready_o);
      // Handshake on this edge
      @(posedge clk_i);
      req_valid_i <= 1'b0;
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk_i);
         check_value("rsp_valid_o", (i == 2), rsp_valid_o);
      end
      held = rsp_o;
      repeat (hold)
      begin
         @(negedge clk_i);
         check_value("rsp_valid_o", 1, rsp_valid_o);
         check_value("rsp_o.rdata", held.rdata, rsp_o.rdata);
         check_value("rsp_o.err", held.err, rsp_o.err);
         check_value("req_ready_o", 0, req_ready_o);
      end
      if (hold > 0)
      begin
         @(posedge clk_i);
         rsp_ready_i <= 1'b1;
      end
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("rsp_valid_o", 0, rsp_valid_o);
      check_value("req_ready_o", 1, req_ready_o);
      rd     = held.rdata;
      rd_err = held.err;
   endtask

   task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                            input logic sup, output soc_pkg::data_t rd,
                            output logic rd_err);
      bus_transfer(1'b1, addr, wdata, sup, 0, rd, rd_err);
   endtask

   task automatic bus_read(input soc_pkg::addr_t addr, input logic sup, input int hold,
                           output soc_pkg::data_t rd, output logic rd_err);
      bus_transfer(1'b0, addr, '0, sup, hold, rd, rd_err);
   endtask

   task automatic acknowledge_fault();
      @(posedge clk_i);
      int_ack_i <= 1'b1;
      @(posedge clk_i);
      int_ack_i <= 1'b0;
      @(negedge clk_i);
   endtask

   task automatic wait_for_code(input soc_pkg::exc_code_t code);
      int n;
      n = 0;
      do
      begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT)
         begin
            fail_run($sformatf("Timeout waiting for exception code %0d", code));
         end
      end while (cpu_interrupt_o !== code);
   endtask

   initial
   begin
      void'($urandom(32'ha2b));
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      rsp_ready_i = 1'b1;
      int_en_i    = 1'b1;
      int_ack_i   = 1'b0;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_value("req_ready_o", 1, req_ready_o);
      check_value("rsp_valid_o", 0, rsp_valid_o);
      check_value("cpu_interrupt_o", soc_pkg::EXC_RESET, cpu_interrupt_o);

      // Fill the whole RAM before mixed random traffic
      for (int i = 0; i < RAM_WORDS; i++)
      begin
         model[i] = $urandom;
         bus_write(i * 4, model[i], 1'b0, rdata, err);
         check_value("rsp_o.err", 0, err);
      end
      for (int i = 0; i < 40; i++)
      begin
         off = $urandom_range(RAM_WORDS - 1);
         if ($urandom_range(1) == 1)
         begin
            model[off] = $urandom;
            bus_write(off * 4, model[off], 1'b0, rdata, err);
         end
         else
         begin
            bus_read(off * 4, 1'b0, 0, rdata, err);
         end
         check_value("rsp_o.rdata", model[off], rdata);
         check_value("rsp_o.err", 0, err);
      end

      // Unmapped region
      bus_read(32'h5000_0000, 1'b1, 0, rdata, err);
      check_value("rsp_o.err", 1, err);
      check_value("rsp_o.rdata", 0, rdata);
      check_value("cpu_interrupt_o", soc_pkg::EXC_MMU, cpu_interrupt_o);
      acknowledge_fault();
      check_value("cpu_interrupt_o", soc_pkg::EXC_RESET, cpu_interrupt_o);

      // Out of bounds write would alias word 0
      bus_write(RAM_WORDS * 4, ~model[0], 1'b0, rdata, err);
      check_value("rsp_o.err", 1, err);
      check_value("rsp_o.rdata", 0, rdata);
      bus_read(32'h0, 1'b0, 0, rdata, err);
      check_value("rsp_o.rdata", model[0], rdata);
      acknowledge_fault();

      // User mode may not touch the timers
      bus_write(TMR_BASE + 4, 32'd2, 1'b0, rdata, err);
      check_value("rsp_o.err", 1, err);
      check_value("cpu_interrupt_o", soc_pkg::EXC_MMU, cpu_interrupt_o);
      acknowledge_fault();
      bus_read(TMR_BASE + 4, 1'b1, 0, rdata, err);
      check_value("rsp_o.rdata", 0, rdata);
      check_value("cpu_interrupt_o", soc_pkg::EXC_RESET, cpu_interrupt_o);
      bus_write(TMR_BASE + 4, 32'h000f_0000, 1'b1, rdata, err);
      check_value("rsp_o.err", 0, err);
      bus_read(TMR_BASE + 4, 1'b1, 0, rdata, err);
      check_value("rsp_o.rdata", 32'h000f_0000, rdata);

      bus_write(TMR_BASE, 32'd3, 1'b1, rdata, err);
      wait_for_code(soc_pkg::EXC_TIMER0);
      bus_write(TMR_BASE + 12, 32'd5, 1'b1, rdata, err);
      polls = 0;
      do
      begin
         bus_read(TMR_BASE + 16, 1'b1, 0, rdata, err);
         polls++;
         if (polls > TIMEOUT)
         begin
            fail_run("Timeout waiting for timers 0 and 3 to be pending");
         end
      end while (rdata[3:0] != 4'b1001);
      check_value("cpu_interrupt_o", soc_pkg::EXC_TIMER3, cpu_interrupt_o);

      // Masked while pending
      @(posedge clk_i);
      int_en_i <= 1'b0;
      @(negedge clk_i);
      check_value("cpu_interrupt_o", soc_pkg::EXC_RESET, cpu_interrupt_o);
      @(posedge clk_i);
      int_en_i <= 1'b1;
      @(negedge clk_i);
      check_value("cpu_interrupt_o", soc_pkg::EXC_TIMER3, cpu_interrupt_o);

      bus_read(TMR_BASE + 16, 1'b1, $urandom_range(8, 1), rdata, err);
      check_value("rsp_o.rdata", 32'h9, rdata);

      bus_write(TMR_BASE + 12, 32'd0, 1'b1, rdata, err);
      bus_write(TMR_BASE + 16, 32'h8, 1'b1, rdata, err);
      check_value("cpu_interrupt_o", soc_pkg::EXC_TIMER0, cpu_interrupt_o);
      bus_write(TMR_BASE, 32'd0, 1'b1, rdata, err);
      bus_write(TMR_BASE + 16, 32'h1, 1'b1, rdata, err);
      check_value("cpu_interrupt_o", soc_pkg::EXC_RESET, cpu_interrupt_o);

      $display("All tests passed");
      $finish;
   end

endmodule

// ==== all.f ====
soc_pkg.sv
bus_decoder.sv
sram_slave.sv
timer_bank.sv
interrupt_encoder.sv
soc_core.sv
tb_soc_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module tb_soc_core -f all.f -o tb_soc_core > build.log 2>&1 \
   && ./obj_dir/tb_soc_core > sim.log 2>&1 \
   || echo "Build or simulation returned an error"
cat build.log sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }
